/* rtl/ahb_cfg.svh */
`ifndef AHB_CFG_SVH
`define AHB_CFG_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

`define AHB_DATA_W 32
`define AHB_ADDR_W 32

//////////////////////////////////////////////////////////////////////
// storage
//////////////////////////////////////////////////////////////////////

// byte count, anything at or above is an error
`define MEM_DEPTH 256

// content of every byte after reset
`define MEM_FILL 8'h0C

`endif

/* rtl/ahb_pkg.sv */
`include "ahb_cfg.svh"

package ahb_pkg;

    // standard AHB transfer codes
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        BUSY   = 2'd1,
        NONSEQ = 2'd2,
        SEQ    = 2'd3
    } htrans_e;

    typedef enum logic [2:0] {
        SINGLE = 3'd0,
        INCR   = 3'd1,
        WRAP4  = 3'd2,
        INCR4  = 3'd3,
        WRAP8  = 3'd4,
        INCR8  = 3'd5,
        WRAP16 = 3'd6,
        INCR16 = 3'd7
    } hburst_e;

    // nothing wider than a word
    typedef enum logic [2:0] {
        BYTE = 3'd0,
        HALF = 3'd1,
        WORD = 3'd2
    } hsize_e;

    typedef enum logic [1:0] {
        OKAY  = 2'd0,
        ERROR = 2'd1
    } hresp_e;

    // one data phase, registered from its address phase
    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic                   err;
        hsize_e                 size;
        hburst_e                burst;
        logic [`AHB_ADDR_W-1:0] addr;
    } xfer_t;

    // byte lanes touched by a transfer of this size at this address
    function automatic logic [3:0] lane_strobe(input hsize_e size, input logic [1:0] addr_lo);
        logic [3:0] strb;
        case (size)
            BYTE:    strb = 4'b0001 << addr_lo;
            HALF:    strb = addr_lo[1] ? 4'b1100 : 4'b0011;
            default: strb = 4'b1111;
        endcase
        return strb;
    endfunction

endpackage

/* rtl/ahb_addr_decode.sv */
`include "ahb_cfg.svh"

module ahb_addr_decode (
    input  logic                   clk,
    input  logic                   hresetn,
    input  logic                   hsel,
    input  ahb_pkg::htrans_e       htrans,
    input  logic                   hwrite,
    input  ahb_pkg::hsize_e        hsize,
    input  ahb_pkg::hburst_e       hburst,
    input  logic [`AHB_ADDR_W-1:0] haddr,
    input  logic                   hready,
    input  logic [`AHB_ADDR_W-1:0] next_addr,
    output ahb_pkg::xfer_t         data_phase
);

    logic                   accept;
    logic [`AHB_ADDR_W-1:0] base_addr;
    logic [`AHB_ADDR_W-1:0] aligned_addr;

    //////////////////////////////////////////////////////////////////////
    // address phase qualification
    //////////////////////////////////////////////////////////////////////

    assign accept = hsel && hready &&
                    (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ);

    // seq beats follow our own address, haddr is ignored
    assign base_addr = (htrans == ahb_pkg::SEQ) ? next_addr : haddr;

    always_comb
    begin
        case (hsize)
            ahb_pkg::HALF: aligned_addr = {base_addr[`AHB_ADDR_W-1:1], 1'b0};
            ahb_pkg::WORD: aligned_addr = {base_addr[`AHB_ADDR_W-1:2], 2'b00};
            default:       aligned_addr = base_addr;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // data phase record
    //////////////////////////////////////////////////////////////////////

    // fields other than valid hold their last beat, so a seq after busy
    // still continues from the right address
    always_ff @(posedge clk)
    begin
        if (!hresetn)
        begin
            data_phase.valid <= 1'b0;
        end
        else if (accept)
        begin
            data_phase.valid <= 1'b1;
            data_phase.write <= hwrite;
            data_phase.err   <= (aligned_addr >= `MEM_DEPTH);
            data_phase.size  <= hsize;
            data_phase.burst <= hburst;
            data_phase.addr  <= aligned_addr;
        end
        else
        begin
            data_phase.valid <= 1'b0;
        end
    end

endmodule

/* rtl/ahb_beat_addr.sv */
`include "ahb_cfg.svh"

module ahb_beat_addr (
    input  ahb_pkg::xfer_t         data_phase,
    output logic [`AHB_ADDR_W-1:0] next_addr
);

    localparam int W = `AHB_ADDR_W;

    logic [W-1:0] size_bytes;
    logic [W-1:0] incr_addr;
    logic [W-1:0] wrap_mask;
    logic [2:0]   beats_log2;

    //////////////////////////////////////////////////////////////////////
    // beat count of a wrapping burst, zero when it does not wrap
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (data_phase.burst)
            ahb_pkg::WRAP4:  beats_log2 = 3'd2;
            ahb_pkg::WRAP8:  beats_log2 = 3'd3;
            ahb_pkg::WRAP16: beats_log2 = 3'd4;
            default:         beats_log2 = 3'd0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // next beat address
    //////////////////////////////////////////////////////////////////////

    assign size_bytes = W'(1) << data_phase.size;
    assign incr_addr  = data_phase.addr + size_bytes;

    // span of the wrap is beats times bytes per beat
    assign wrap_mask = (size_bytes << beats_log2) - W'(1);

    always_comb
    begin
        if (beats_log2 != 3'd0)
        begin
            // low bits wrap inside the span, upper bits stay put
            next_addr = (data_phase.addr & ~wrap_mask) | (incr_addr & wrap_mask);
        end
        else
        begin
            next_addr = incr_addr;
        end
    end

endmodule

/* rtl/ahb_byte_mem.sv */
`include "ahb_cfg.svh"

module ahb_byte_mem (
    input  logic                   clk,
    input  logic                   hresetn,
    input  ahb_pkg::xfer_t         data_phase,
    input  logic [`AHB_DATA_W-1:0] hwdata,
    output logic [`AHB_DATA_W-1:0] rd_word
);

    localparam int LANES = `AHB_DATA_W / 8;
    localparam int WORDS = `MEM_DEPTH / LANES;
    localparam int IDX_W = $clog2(WORDS);

    logic [IDX_W-1:0] word_idx;
    logic [LANES-1:0] strb;
    logic             wr_en;

    //////////////////////////////////////////////////////////////////////
    // write control
    //////////////////////////////////////////////////////////////////////

    assign word_idx = data_phase.addr[IDX_W+1:2];
    assign wr_en    = data_phase.valid && data_phase.write && !data_phase.err;
    assign strb     = ahb_pkg::lane_strobe(data_phase.size, data_phase.addr[1:0]);

    //////////////////////////////////////////////////////////////////////
    // one storage array per byte lane
    //////////////////////////////////////////////////////////////////////

    for (genvar l = 0; l < LANES; l++)
    begin : g_lane
        logic [7:0] lane_q [WORDS];

        // hwdata belongs to the data phase that ends at this edge
        always_ff @(posedge clk)
        begin
            if (!hresetn)
            begin
                for (int i = 0; i < WORDS; i++)
                begin
                    lane_q[i] <= `MEM_FILL;
                end
            end
            else if (wr_en && strb[l])
            begin
                lane_q[word_idx] <= hwdata[8*l +: 8];
            end
        end

        // whole aligned word, lane selection happens in the response
        assign rd_word[8*l +: 8] = lane_q[word_idx];
    end

endmodule

/* rtl/ahb_resp_gen.sv */
`include "ahb_cfg.svh"

module ahb_resp_gen (
    input  logic                   clk,
    input  logic                   hresetn,
    input  ahb_pkg::xfer_t         data_phase,
    input  logic [`AHB_DATA_W-1:0] rd_word,
    output logic                   hready,
    output ahb_pkg::hresp_e        hresp,
    output logic [`AHB_DATA_W-1:0] hrdata
);

    localparam int LANES = `AHB_DATA_W / 8;

    logic             err_first;
    logic             err_second;
    logic             rd_valid;
    logic [LANES-1:0] strb;

    //////////////////////////////////////////////////////////////////////
    // two-cycle error response
    //////////////////////////////////////////////////////////////////////

    assign err_first = data_phase.valid && data_phase.err;

    // second cycle follows the first unconditionally
    always_ff @(posedge clk)
    begin
        if (!hresetn)
        begin
            err_second <= 1'b0;
        end
        else
        begin
            err_second <= err_first;
        end
    end

    // stall only in the first error cycle
    assign hready = !err_first;
    assign hresp  = (err_first || err_second) ? ahb_pkg::ERROR : ahb_pkg::OKAY;

    //////////////////////////////////////////////////////////////////////
    // read data
    //////////////////////////////////////////////////////////////////////

    assign rd_valid = data_phase.valid && !data_phase.write && !data_phase.err;
    assign strb     = ahb_pkg::lane_strobe(data_phase.size, data_phase.addr[1:0]);

    // lanes outside the transfer read as zero
    for (genvar l = 0; l < LANES; l++)
    begin : g_rd_lane
        assign hrdata[8*l +: 8] = (rd_valid && strb[l]) ? rd_word[8*l +: 8] : 8'h00;
    end

endmodule

/* rtl/ahb_mem_slave.sv */
`include "ahb_cfg.svh"

module ahb_mem_slave (
    input  logic                   clk,
    input  logic                   hresetn,
    input  logic                   hsel,
    input  logic                   hwrite,
    input  ahb_pkg::htrans_e       htrans,
    input  ahb_pkg::hsize_e        hsize,
    input  ahb_pkg::hburst_e       hburst,
    input  logic [`AHB_ADDR_W-1:0] haddr,
    input  logic [`AHB_DATA_W-1:0] hwdata,
    output logic                   hready,
    output ahb_pkg::hresp_e        hresp,
    output logic [`AHB_DATA_W-1:0] hrdata
);

    ahb_pkg::xfer_t         data_phase;
    logic [`AHB_ADDR_W-1:0] next_addr;
    logic [`AHB_DATA_W-1:0] rd_word;

    //////////////////////////////////////////////////////////////////////
    // address phase to data phase
    //////////////////////////////////////////////////////////////////////

    ahb_addr_decode u_decode (
        .clk        (clk),
        .hresetn    (hresetn),
        .hsel       (hsel),
        .htrans     (htrans),
        .hwrite     (hwrite),
        .hsize      (hsize),
        .hburst     (hburst),
        .haddr      (haddr),
        .hready     (hready),
        .next_addr  (next_addr),
        .data_phase (data_phase)
    );

    // address of the following seq beat
    ahb_beat_addr u_beat_addr (
        .data_phase (data_phase),
        .next_addr  (next_addr)
    );

    //////////////////////////////////////////////////////////////////////
    // execute and respond
    //////////////////////////////////////////////////////////////////////

    ahb_byte_mem u_mem (
        .clk        (clk),
        .hresetn    (hresetn),
        .data_phase (data_phase),
        .hwdata     (hwdata),
        .rd_word    (rd_word)
    );

    ahb_resp_gen u_resp (
        .clk        (clk),
        .hresetn    (hresetn),
        .data_phase (data_phase),
        .rd_word    (rd_word),
        .hready     (hready),
        .hresp      (hresp),
        .hrdata     (hrdata)
    );

endmodule

/* test/tb_ahb_mem_slave.sv */
`include "ahb_cfg.svh"

module tb_ahb_mem_slave;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 20;

    logic                   clk;
    logic                   hresetn;
    logic                   hsel;
    logic                   hwrite;
    ahb_pkg::htrans_e       htrans;
    ahb_pkg::hsize_e        hsize;
    ahb_pkg::hburst_e       hburst;
    logic [`AHB_ADDR_W-1:0] haddr;
    logic [`AHB_DATA_W-1:0] hwdata;
    logic                   hready;
    ahb_pkg::hresp_e        hresp;
    logic [`AHB_DATA_W-1:0] hrdata;

    // reference model state
    logic [7:0]             model [`MEM_DEPTH];
    ahb_pkg::xfer_t         dphase;
    logic [`AHB_ADDR_W-1:0] last_addr;
    ahb_pkg::hsize_e        last_size;
    ahb_pkg::hburst_e       last_burst;
    logic                   err_tail;
    logic                   run_checks;

    int    seed;
    int    checks;
    int    errors;
    int    timeouts;
    string test_name;
    string check_name;

    ahb_mem_slave u_dut (
        .clk     (clk),
        .hresetn (hresetn),
        .hsel    (hsel),
        .hwrite  (hwrite),
        .htrans  (htrans),
        .hsize   (hsize),
        .hburst  (hburst),
        .haddr   (haddr),
        .hwdata  (hwdata),
        .hready  (hready),
        .hresp   (hresp),
        .hrdata  (hrdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // model helpers
    //////////////////////////////////////////////////////////////////////

    function automatic int size_bytes(input ahb_pkg::hsize_e size);
        return 1 << size;
    endfunction

    function automatic int wrap_beats(input ahb_pkg::hburst_e burst);
        case (burst)
            ahb_pkg::WRAP4:  return 4;
            ahb_pkg::WRAP8:  return 8;
            ahb_pkg::WRAP16: return 16;
            default:         return 0;
        endcase
    endfunction

    // address of the beat after addr
    function automatic logic [31:0] follow_addr(input logic [31:0] addr,
                                                input ahb_pkg::hsize_e size,
                                                input ahb_pkg::hburst_e burst);
        int          step;
        int          span;
        logic [31:0] base;
        step = size_bytes(size);
        span = wrap_beats(burst) * step;
        if (span == 0)
            return addr + step;
        base = addr - (addr % span);
        return base + ((addr - base + step) % span);
    endfunction

    // model bytes on their own lanes and zero on the others
    function automatic logic [31:0] expected_rdata(input logic [31:0] addr,
                                                   input ahb_pkg::hsize_e size);
        logic [31:0] word;
        int          lane;
        word = '0;
        for (int b = 0; b < size_bytes(size); b++)
        begin
            lane = (addr + b) % 4;
            word[8*lane +: 8] = model[addr + b];
        end
        return word;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // model update at each rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin : model_update
        logic [31:0] a;
        int          idx;
        logic        ready_now;
        run_checks = hresetn;
        check_name = test_name;
        if (!hresetn)
        begin
            for (int i = 0; i < `MEM_DEPTH; i++)
                model[i] = `MEM_FILL;
            dphase   = '0;
            err_tail = 1'b0;
        end
        else
        begin
            // slave stalls only in the first cycle of an error
            ready_now = !(dphase.valid && dphase.err);
            // data phase ending here takes hwdata of this edge
            if (dphase.valid && dphase.write && !dphase.err)
            begin
                for (int b = 0; b < size_bytes(dphase.size); b++)
                begin
                    idx        = dphase.addr + b;
                    model[idx] = hwdata[8*(idx % 4) +: 8];
                end
            end
            err_tail = dphase.valid && dphase.err;
            if (hsel && ready_now && (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ))
            begin
                a = (htrans == ahb_pkg::SEQ) ? follow_addr(last_addr, last_size, last_burst)
                                             : haddr;
                a = a & ~(size_bytes(hsize) - 1);
                dphase.valid = 1'b1;
                dphase.write = hwrite;
                dphase.err   = (a >= `MEM_DEPTH);
                dphase.size  = hsize;
                dphase.burst = hburst;
                dphase.addr  = a;
                last_addr    = a;
                last_size    = hsize;
                last_burst   = hburst;
            end
            else
                dphase.valid = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // data phase checks at mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin : check_phase
        logic            exp_ready;
        ahb_pkg::hresp_e exp_resp;
        logic [31:0]     exp_data;
        if (run_checks)
        begin
            exp_ready = !(dphase.valid && dphase.err);
            exp_resp  = ((dphase.valid && dphase.err) || err_tail) ? ahb_pkg::ERROR
                                                                    : ahb_pkg::OKAY;
            checks++;
            assert (hready === exp_ready && hresp === exp_resp)
            else
            begin
                $display("Error: %s expected hready=%0b hresp=%0d, actual hready=%0b hresp=%0d",
                         check_name, exp_ready, exp_resp, hready, hresp);
                errors++;
            end
            if (dphase.valid && !dphase.write && !dphase.err)
            begin
                exp_data = expected_rdata(dphase.addr, dphase.size);
                checks++;
                assert (hrdata === exp_data)
                else
                begin
                    $display("Error: %s read at %h expected %h, actual %h",
                             check_name, dphase.addr, exp_data, hrdata);
                    errors++;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bus master tasks
    //////////////////////////////////////////////////////////////////////

    task automatic wait_ready();
        int n;
        n = 0;
        while (!hready && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!hready)
        begin
            $display("Timeout in %s: hready stayed low for %0d cycles", test_name, WAIT_LIMIT);
            timeouts++;
            errors++;
        end
    endtask

    // seq beats carry a junk haddr
    task automatic run_burst(input logic write, input ahb_pkg::hburst_e burst,
                             input ahb_pkg::hsize_e size, input logic [31:0] start,
                             input int beats);
        logic [31:0] wdata;
        wdata = $random(seed);
        for (int i = 0; i < beats; i++)
        begin
            @(negedge clk);
            wait_ready();
            hsel   = 1'b1;
            hwrite = write;
            hsize  = size;
            hburst = burst;
            htrans = (i == 0) ? ahb_pkg::NONSEQ : ahb_pkg::SEQ;
            haddr  = (i == 0) ? start : $random(seed);
            if (i > 0)
                hwdata = wdata;
            wdata = $random(seed);
        end
        @(negedge clk);
        htrans = ahb_pkg::IDLE;
        hwdata = wdata;
    endtask

    task automatic write_then_read(input ahb_pkg::hburst_e burst, input ahb_pkg::hsize_e size,
                                   input logic [31:0] start, input int beats);
        run_burst(1'b1, burst, size, start, beats);
        run_burst(1'b0, burst, size, start, beats);
    endtask

    // out-of-range access with the master idle through both error cycles
    task automatic error_access(input logic write, input logic [31:0] addr);
        @(negedge clk);
        wait_ready();
        hsel   = 1'b1;
        hwrite = write;
        hsize  = ahb_pkg::WORD;
        hburst = ahb_pkg::SINGLE;
        htrans = ahb_pkg::NONSEQ;
        haddr  = addr;
        @(negedge clk);
        htrans = ahb_pkg::IDLE;
        hwdata = $random(seed);
        repeat (2) @(negedge clk);
    endtask

    task automatic non_transfer(input logic sel, input ahb_pkg::htrans_e trans);
        @(negedge clk);
        wait_ready();
        hsel   = sel;
        hwrite = 1'b1;
        hsize  = ahb_pkg::WORD;
        hburst = ahb_pkg::SINGLE;
        htrans = trans;
        haddr  = $random(seed) & 32'hFC;
        @(negedge clk);
        hsel   = 1'b1;
        htrans = ahb_pkg::IDLE;
        hwdata = $random(seed);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        ahb_pkg::hburst_e wraps [3];
        int               span;
        wraps    = '{ahb_pkg::WRAP4, ahb_pkg::WRAP8, ahb_pkg::WRAP16};
        seed     = 80215;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        hresetn  = 1'b0;
        hsel     = 1'b0;
        hwrite   = 1'b0;
        htrans   = ahb_pkg::IDLE;
        hsize    = ahb_pkg::WORD;
        hburst   = ahb_pkg::SINGLE;
        haddr    = '0;
        hwdata   = '0;
        test_name = "reset";
        repeat (10) @(negedge clk);
        hresetn = 1'b1;

        for (int a = 0; a < `MEM_DEPTH; a += 36)
            run_burst(1'b0, ahb_pkg::SINGLE, ahb_pkg::WORD, a, 1);

        test_name = "single";
        run_burst(1'b1, ahb_pkg::SINGLE, ahb_pkg::BYTE, 32'h11, 1);
        run_burst(1'b1, ahb_pkg::SINGLE, ahb_pkg::HALF, 32'h16, 1);
        run_burst(1'b1, ahb_pkg::SINGLE, ahb_pkg::WORD, 32'h18, 1);
        run_burst(1'b0, ahb_pkg::SINGLE, ahb_pkg::BYTE, 32'h11, 1);
        run_burst(1'b0, ahb_pkg::SINGLE, ahb_pkg::HALF, 32'h16, 1);
        for (int a = 32'h10; a <= 32'h18; a += 4)
            run_burst(1'b0, ahb_pkg::SINGLE, ahb_pkg::WORD, a, 1);

        test_name = "incr";
        write_then_read(ahb_pkg::INCR4, ahb_pkg::WORD, 32'h20, 4);
        write_then_read(ahb_pkg::INCR8, ahb_pkg::HALF, 32'h30, 8);
        write_then_read(ahb_pkg::INCR16, ahb_pkg::BYTE, 32'h42, 16);
        write_then_read(ahb_pkg::INCR16, ahb_pkg::WORD, 32'h40, 16);
        write_then_read(ahb_pkg::INCR, ahb_pkg::WORD, 32'h90, 5);

        // start past the middle of the span so every burst wraps
        test_name = "wrap";
        for (int s = 0; s < 3; s++)
        begin
            for (int w = 0; w < 3; w++)
            begin
                span = wrap_beats(wraps[w]) << s;
                write_then_read(wraps[w], ahb_pkg::hsize_e'(s),
                                32'hC0 + span / 2 + (1 << s), wrap_beats(wraps[w]));
            end
        end

        test_name = "error";
        error_access(1'b1, 32'h100);
        error_access(1'b0, 32'hFFFF_FFF0);
        error_access(1'b1, 32'h1FC);

        test_name = "non_transfer";
        non_transfer(1'b1, ahb_pkg::IDLE);
        non_transfer(1'b1, ahb_pkg::BUSY);
        non_transfer(1'b0, ahb_pkg::NONSEQ);
        non_transfer(1'b0, ahb_pkg::SEQ);

        test_name = "final_sweep";
        for (int a = 0; a < `MEM_DEPTH; a += 4)
            run_burst(1'b0, ahb_pkg::SINGLE, ahb_pkg::WORD, a, 1);
        repeat (2) @(negedge clk);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+rtl
rtl/ahb_pkg.sv
rtl/ahb_addr_decode.sv
rtl/ahb_beat_addr.sv
rtl/ahb_byte_mem.sv
rtl/ahb_resp_gen.sv
rtl/ahb_mem_slave.sv
test/tb_ahb_mem_slave.sv
